/* Bender.yml */
package:
  name: system

sources:
  - soc_pkg.sv
  - wb_conbus.sv
  - wb_bram.sv
  - wb_sram16.sv
  - norflash16.sv
  - mem_bus_sel.sv
  - wb_gpio.sv
  - system.sv
  - target: test
    files:
      - tb_system.sv

/* mem_bus_sel.sv */
// Shares the external address, data and strobe pins between PSRAM and flash
// PSRAM wins if both chip enables are low
// Data pins are driven only while a PSRAM write holds ce low and oe high
module mem_bus_sel import soc_pkg::*; (
	input  logic [SRAM_AW-1:0]  sram_adr_i,
	input  logic [MEM_DW-1:0]   sram_dat_i,
	input  logic                sram_oe_n_i,
	input  logic                sram_we_n_i,
	input  logic                sram_ce_n_i,
	input  logic [FLASH_AW-1:0] flash_adr_i,
	input  logic                flash_oe_n_i,
	input  logic                flash_ce_n_i,
	output logic [MEM_DW-1:0]   sram_dat_o,
	output logic [MEM_DW-1:0]   flash_dat_o,
	// Shared pins
	output logic [MEM_AW-1:0]   mem_adr_o,
	inout  wire  [MEM_DW-1:0]   mem_d_io,
	output logic                mem_oe_n_o,
	output logic                mem_we_n_o
);

	logic drive;

	always_comb begin
		// Idle pins, strobes inactive
		mem_adr_o  = '0;
		mem_oe_n_o = 1'b1;
		mem_we_n_o = 1'b1;
		if (!sram_ce_n_i) begin
			mem_adr_o  = MEM_AW'(sram_adr_i);
			mem_oe_n_o = sram_oe_n_i;
			mem_we_n_o = sram_we_n_i;
		end else if (!flash_ce_n_i) begin
			// Flash write-enable never asserted
			mem_adr_o  = MEM_AW'(flash_adr_i);
			mem_oe_n_o = flash_oe_n_i;
		end
	end

	assign drive    = ~sram_ce_n_i & sram_oe_n_i;
	assign mem_d_io = drive ? sram_dat_i : 'z;

	// Pin data back to both controllers
	assign sram_dat_o  = mem_d_io;
	assign flash_dat_o = mem_d_io;

endmodule

/* norflash16.sv */
// Read-only Wishbone access to a 16-bit NOR flash
// High half-word first, from the even half-word address
// Writes are acknowledged after one cycle and never reach the pins
module norflash16 import soc_pkg::*; (
	input  logic                clk,
	input  logic                rst_i,
	input  wb_addr_t            adr_i,
	input  logic                we_i,
	input  logic                stb_i,
	output logic [WB_DW-1:0]    dat_o,
	output logic                ack_o,
	// Flash side
	output logic [FLASH_AW-1:0] flash_adr_o,
	input  logic [MEM_DW-1:0]   flash_dat_i,
	output logic                flash_ce_n_o,
	output logic                flash_oe_n_o
);

	logic             busy;
	logic             second;
	logic [LAT_W-1:0] cnt;

	// Two read windows, address steps between them
	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy         <= 1'b0;
			second       <= 1'b0;
			cnt          <= '0;
			ack_o        <= 1'b0;
			flash_ce_n_o <= 1'b1;
			flash_oe_n_o <= 1'b1;
		end else begin
			ack_o <= 1'b0;
			if (!busy) begin
				if (stb_i && !ack_o) begin
					if (we_i) begin
						ack_o <= 1'b1;
					end else begin
						busy         <= 1'b1;
						second       <= 1'b0;
						cnt          <= LAT_W'(FLASH_LATENCY - 1);
						flash_ce_n_o <= 1'b0;
						flash_oe_n_o <= 1'b0;
					end
				end
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else if (!second) begin
				second <= 1'b1;
				cnt    <= LAT_W'(FLASH_LATENCY - 1);
			end else begin
				busy         <= 1'b0;
				ack_o        <= 1'b1;
				flash_ce_n_o <= 1'b1;
				flash_oe_n_o <= 1'b1;
			end
		end
	end

	// Big-endian word assembly
	always_ff @(posedge clk) begin
		if (!busy) begin
			flash_adr_o <= {adr_i.rgn.offset[FLASH_AW:2], 1'b0};
		end else if (cnt == '0) begin
			if (!second) begin
				dat_o[WB_DW-1:MEM_DW] <= flash_dat_i;
				flash_adr_o[0]        <= 1'b1;
			end else begin
				dat_o[MEM_DW-1:0] <= flash_dat_i;
			end
		end
	end

endmodule

/* soc_pkg.sv */
// Shared address map, bus widths and external memory timing
// Latencies count clock cycles, so they must be retuned with the clock
// Block RAM and GPIO are decoded on the page field, memories on the region field
package soc_pkg;

	// Wishbone bus
	localparam int WB_AW   = 32;
	localparam int WB_DW   = 32;
	localparam int WB_SELW = 4;

	// Shared external memory pins
	localparam int MEM_AW = 26;
	localparam int MEM_DW = 16;

	// Address map
	localparam int REGION_W = 3;
	localparam int PAGE_W   = 15;
	localparam logic [REGION_W-1:0] REGION_SRAM  = 3'd4;
	localparam logic [REGION_W-1:0] REGION_FLASH = 3'd5;
	localparam logic [PAGE_W-1:0]   PAGE_BRAM    = 15'h0000;
	localparam logic [PAGE_W-1:0]   PAGE_GPIO    = 15'h7002;

	// Device address widths, PSRAM and flash in half-words
	localparam int SRAM_AW  = 23;
	localparam int FLASH_AW = 24;
	localparam int BRAM_AW  = 12;

	// Strobe hold time per half-word access
	localparam int SRAM_LATENCY  = 5;
	localparam int FLASH_LATENCY = 7;
	// Counter width, sized for the slower device
	localparam int LAT_W = $clog2(FLASH_LATENCY);

	// Same bus address, seen as region or as page
	typedef union packed {
		struct packed {
			logic [REGION_W-1:0]       region;
			logic [WB_AW-REGION_W-1:0] offset;
		} rgn;
		struct packed {
			logic [PAGE_W-1:0]       page;
			logic [WB_AW-PAGE_W-1:0] offset;
		} pg;
	} wb_addr_t;

	typedef enum logic [2:0] {
		SLV_NONE,
		SLV_SRAM,
		SLV_FLASH,
		SLV_BRAM,
		SLV_GPIO
	} slave_e;

endpackage

/* system.f */
soc_pkg.sv
wb_conbus.sv
wb_bram.sv
wb_sram16.sv
norflash16.sv
mem_bus_sel.sv
wb_gpio.sv
system.sv
tb_system.sv

/* system.sv */
// Bus fabric and memory side of the soft-processor SoC
// Both Wishbone masters come in at the ports in place of the CPU
// PSRAM and flash share mem_adr_o, mem_d_io, mem_oe_n_o and mem_we_n_o
module system import soc_pkg::*; (
	input  logic                clk,
	input  logic                rst_i,
	// Instruction master
	input  logic [WB_AW-1:0]    i_adr_i,
	input  logic [WB_DW-1:0]    i_dat_w_i,
	input  logic [WB_SELW-1:0]  i_sel_i,
	input  logic                i_we_i, i_cyc_i, i_stb_i,
	output logic [WB_DW-1:0]    i_dat_r_o,
	output logic                i_ack_o, i_err_o,
	// Data master
	input  logic [WB_AW-1:0]    d_adr_i,
	input  logic [WB_DW-1:0]    d_dat_w_i,
	input  logic [WB_SELW-1:0]  d_sel_i,
	input  logic                d_we_i, d_cyc_i, d_stb_i,
	output logic [WB_DW-1:0]    d_dat_r_o,
	output logic                d_ack_o, d_err_o,
	// Board
	input  logic [3:0]          btn_i,
	output logic [7:0]          led_o,
	// External memory
	output logic [MEM_AW-1:0]   mem_adr_o,
	inout  wire  [MEM_DW-1:0]   mem_d_io,
	output logic                mem_oe_n_o, mem_we_n_o,
	output logic                sram_ce_n_o, sram_ub_n_o, sram_lb_n_o,
	output logic                flash_ce_n_o
);

	// Shared slave request
	wb_addr_t            bus_adr;
	logic [WB_DW-1:0]    bus_dat_w;
	logic [WB_SELW-1:0]  bus_sel;
	logic                bus_we;
	// Per-slave strobe and response
	logic                sram_stb, flash_stb, bram_stb, gpio_stb;
	logic                sram_ack, flash_ack, bram_ack, gpio_ack;
	logic [WB_DW-1:0]    sram_dat_r, flash_dat_r, bram_dat_r, gpio_dat_r;
	// Controller side of the pin selector
	logic [SRAM_AW-1:0]  sram_adr;
	logic [FLASH_AW-1:0] flash_adr;
	logic [MEM_DW-1:0]   sram_dq_w, sram_dq_r, flash_dq_r;
	logic                sram_oe_n, sram_we_n, flash_oe_n;

	//--------------------------------------------------------------------------
	// Interconnect, no slave takes cyc
	//--------------------------------------------------------------------------
	wb_conbus conmax0 (
		.clk(clk), .rst_i(rst_i),
		.i_adr_i(i_adr_i), .i_dat_w_i(i_dat_w_i), .i_sel_i(i_sel_i),
		.i_we_i(i_we_i), .i_cyc_i(i_cyc_i), .i_stb_i(i_stb_i),
		.i_dat_r_o(i_dat_r_o), .i_ack_o(i_ack_o), .i_err_o(i_err_o),
		.d_adr_i(d_adr_i), .d_dat_w_i(d_dat_w_i), .d_sel_i(d_sel_i),
		.d_we_i(d_we_i), .d_cyc_i(d_cyc_i), .d_stb_i(d_stb_i),
		.d_dat_r_o(d_dat_r_o), .d_ack_o(d_ack_o), .d_err_o(d_err_o),
		.adr_o(bus_adr), .dat_o(bus_dat_w), .sel_o(bus_sel), .we_o(bus_we), .cyc_o(),
		.sram_stb_o(sram_stb), .flash_stb_o(flash_stb),
		.bram_stb_o(bram_stb), .gpio_stb_o(gpio_stb),
		.sram_dat_i(sram_dat_r), .flash_dat_i(flash_dat_r),
		.bram_dat_i(bram_dat_r), .gpio_dat_i(gpio_dat_r),
		.sram_ack_i(sram_ack), .flash_ack_i(flash_ack),
		.bram_ack_i(bram_ack), .gpio_ack_i(gpio_ack)
	);

	//--------------------------------------------------------------------------
	// On-chip slaves
	//--------------------------------------------------------------------------
	wb_bram bram0 (
		.clk(clk), .rst_i(rst_i), .adr_i(bus_adr), .dat_i(bus_dat_w),
		.sel_i(bus_sel), .we_i(bus_we), .stb_i(bram_stb),
		.dat_o(bram_dat_r), .ack_o(bram_ack)
	);

	wb_gpio gpio0 (
		.clk(clk), .rst_i(rst_i), .adr_i(bus_adr), .dat_i(bus_dat_w),
		.sel_i(bus_sel), .we_i(bus_we), .stb_i(gpio_stb),
		.dat_o(gpio_dat_r), .ack_o(gpio_ack), .btn_i(btn_i), .led_o(led_o)
	);

	//--------------------------------------------------------------------------
	// External memories
	//--------------------------------------------------------------------------
	// Byte enables: bit 1 is the upper byte
	wb_sram16 sram0 (
		.clk(clk), .rst_i(rst_i), .adr_i(bus_adr), .dat_i(bus_dat_w),
		.sel_i(bus_sel), .we_i(bus_we), .stb_i(sram_stb),
		.dat_o(sram_dat_r), .ack_o(sram_ack),
		.sram_adr_o(sram_adr), .sram_dat_o(sram_dq_w), .sram_dat_i(sram_dq_r),
		.sram_be_n_o({sram_ub_n_o, sram_lb_n_o}), .sram_ce_n_o(sram_ce_n_o),
		.sram_oe_n_o(sram_oe_n), .sram_we_n_o(sram_we_n)
	);

	norflash16 norflash0 (
		.clk(clk), .rst_i(rst_i), .adr_i(bus_adr), .we_i(bus_we), .stb_i(flash_stb),
		.dat_o(flash_dat_r), .ack_o(flash_ack),
		.flash_adr_o(flash_adr), .flash_dat_i(flash_dq_r),
		.flash_ce_n_o(flash_ce_n_o), .flash_oe_n_o(flash_oe_n)
	);

	mem_bus_sel memsel0 (
		.sram_adr_i(sram_adr), .sram_dat_i(sram_dq_w), .sram_oe_n_i(sram_oe_n),
		.sram_we_n_i(sram_we_n), .sram_ce_n_i(sram_ce_n_o),
		.flash_adr_i(flash_adr), .flash_oe_n_i(flash_oe_n), .flash_ce_n_i(flash_ce_n_o),
		.sram_dat_o(sram_dq_r), .flash_dat_o(flash_dq_r),
		.mem_adr_o(mem_adr_o), .mem_d_io(mem_d_io),
		.mem_oe_n_o(mem_oe_n_o), .mem_we_n_o(mem_we_n_o)
	);

endmodule

/* tb_system.sv */
// Drives both Wishbone masters at the top level and models PSRAM and flash on the pins
// Pin models hold 256 half-words, so test addresses stay in the low words
// All writes go through the data master; reads use both masters
module tb_system import soc_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int M_INSTR = 0;
	localparam int M_DATA  = 1;
	localparam int T_BRAM  = 0;
	localparam int T_SRAM  = 1;
	localparam int T_FLASH = 2;
	localparam int N_WORDS = 16;
	localparam int N_MIX   = 32;
	localparam int N_FLASH = 16;
	localparam int N_FWR   = 4;
	localparam int N_PAIR  = 16;
	localparam int N_LED   = 4;
	localparam int N_BTN   = 2;
	localparam int N_XFERS = 2 * (2 * N_WORDS + N_MIX) + N_FLASH + 2 * N_FWR
		+ 2 * N_PAIR + N_LED + 1 + N_BTN + 2;
	// Worst access doubled for every transfer, plus reset
	localparam longint WATCHDOG_TIME =
		longint'(N_XFERS * 2 * (2 * FLASH_LATENCY + 4) + RESET_CYCLES) * CLK_PERIOD;

	localparam logic [WB_AW-1:0] BRAM_BASE  = {PAGE_BRAM, {(WB_AW-PAGE_W){1'b0}}};
	localparam logic [WB_AW-1:0] GPIO_BASE  = {PAGE_GPIO, {(WB_AW-PAGE_W){1'b0}}};
	localparam logic [WB_AW-1:0] BAD_BASE   = {15'h7005, {(WB_AW-PAGE_W){1'b0}}};
	localparam logic [WB_AW-1:0] SRAM_BASE  = {REGION_SRAM, {(WB_AW-REGION_W){1'b0}}};
	localparam logic [WB_AW-1:0] FLASH_BASE = {REGION_FLASH, {(WB_AW-REGION_W){1'b0}}};

	logic                clk;
	logic                rst;
	logic [WB_AW-1:0]    i_adr, d_adr;
	logic [WB_DW-1:0]    i_dat_w, d_dat_w, i_dat_r, d_dat_r;
	logic [WB_SELW-1:0]  i_sel, d_sel;
	logic                i_we, i_cyc, i_stb, i_ack, i_err;
	logic                d_we, d_cyc, d_stb, d_ack, d_err;
	logic [3:0]          btn;
	logic [7:0]          led;
	logic [MEM_AW-1:0]   mem_adr;
	wire  [MEM_DW-1:0]   mem_d;
	logic                mem_oe_n, mem_we_n;
	logic                sram_ce_n, sram_ub_n, sram_lb_n, flash_ce_n;

	// Pin-side device arrays and reference words
	logic [MEM_DW-1:0]   psram_pins [0:255];
	logic [MEM_DW-1:0]   flash_pins [0:255];
	logic [WB_DW-1:0]    bram_ref [0:N_WORDS-1];
	logic [WB_DW-1:0]    sram_ref [0:N_WORDS-1];
	logic                active [0:1];
	time                 ack_time [0:1];
	logic                ce_low_seen;
	integer              seed = 97;
	int                  checks;
	int                  errors;

	system dut0 (
		.clk(clk), .rst_i(rst),
		.i_adr_i(i_adr), .i_dat_w_i(i_dat_w), .i_sel_i(i_sel),
		.i_we_i(i_we), .i_cyc_i(i_cyc), .i_stb_i(i_stb),
		.i_dat_r_o(i_dat_r), .i_ack_o(i_ack), .i_err_o(i_err),
		.d_adr_i(d_adr), .d_dat_w_i(d_dat_w), .d_sel_i(d_sel),
		.d_we_i(d_we), .d_cyc_i(d_cyc), .d_stb_i(d_stb),
		.d_dat_r_o(d_dat_r), .d_ack_o(d_ack), .d_err_o(d_err),
		.btn_i(btn), .led_o(led),
		.mem_adr_o(mem_adr), .mem_d_io(mem_d), .mem_oe_n_o(mem_oe_n), .mem_we_n_o(mem_we_n),
		.sram_ce_n_o(sram_ce_n), .sram_ub_n_o(sram_ub_n), .sram_lb_n_o(sram_lb_n),
		.flash_ce_n_o(flash_ce_n)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//--------------------------------------------------------------------------
	// Memory devices on the shared pins
	//--------------------------------------------------------------------------
	// Read data while oe is low, PSRAM or flash by chip enable
	assign mem_d = (!mem_oe_n && !sram_ce_n) ? psram_pins[mem_adr[7:0]] :
		(!mem_oe_n && !flash_ce_n) ? flash_pins[mem_adr[7:0]] : 'z;

	// PSRAM write on the falling we edge, pins settle first
	always @(negedge mem_we_n) begin
		#1;
		if (!sram_ce_n) begin
			if (!sram_lb_n)
				psram_pins[mem_adr[7:0]][7:0] = mem_d[7:0];
			if (!sram_ub_n)
				psram_pins[mem_adr[7:0]][15:8] = mem_d[15:8];
		end
	end

	// Stray responses and chip enables
	always @(negedge clk) begin
		if (!rst && !active[M_DATA] && (d_ack || d_err))
			report_failure("data master got a response it did not request");
		if (!rst && !active[M_INSTR] && (i_ack || i_err))
			report_failure("instruction master got a response it did not request");
		if (!sram_ce_n || !flash_ce_n)
			ce_low_seen = 1'b1;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout: run did not finish within %0d time units", WATCHDOG_TIME);
		$display("Test failed");
		$finish;
	end

	//--------------------------------------------------------------------------
	// Checks
	//--------------------------------------------------------------------------
	task automatic report_failure(input string what);
		errors++;
		$display("At %0t: %s", $time, what);
	endtask

	task automatic check_data(input string name, input logic [WB_DW-1:0] got,
			input logic [WB_DW-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_half(input string name, input logic [MEM_DW-1:0] got,
			input logic [MEM_DW-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: led_o = %h, expected %h", $time, got, exp);
		end
	endtask

	//--------------------------------------------------------------------------
	// Reference model
	//--------------------------------------------------------------------------
	function automatic logic [WB_AW-1:0] addr_of(input int t, input int w);
		logic [WB_AW-1:0] base;
		case (t)
			T_BRAM:  base = BRAM_BASE;
			T_SRAM:  base = SRAM_BASE;
			default: base = FLASH_BASE;
		endcase
		return base + WB_AW'(4 * w);
	endfunction

	// Big-endian flash word from two half-words
	function automatic logic [WB_DW-1:0] flash_word(input int w);
		return {flash_pins[2 * w], flash_pins[2 * w + 1]};
	endfunction

	function automatic logic [WB_DW-1:0] ref_get(input int t, input int w);
		if (t == T_BRAM)
			return bram_ref[w];
		else if (t == T_SRAM)
			return sram_ref[w];
		return flash_word(w);
	endfunction

	function automatic void ref_set(input int t, input int w, input logic [WB_DW-1:0] v);
		if (t == T_BRAM)
			bram_ref[w] = v;
		else
			sram_ref[w] = v;
	endfunction

	function automatic logic [WB_DW-1:0] merge(input logic [WB_DW-1:0] old_w,
			input logic [WB_DW-1:0] new_w, input logic [WB_SELW-1:0] sel);
		logic [WB_DW-1:0] res;
		res = old_w;
		for (int b = 0; b < WB_SELW; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	function automatic string rdata_name(input int m);
		return (m == M_DATA) ? "d_dat_r_o" : "i_dat_r_o";
	endfunction

	//--------------------------------------------------------------------------
	// Master side
	//--------------------------------------------------------------------------
	task automatic drive_req(input int m, input logic [WB_AW-1:0] adr,
			input logic [WB_DW-1:0] wdat, input logic [WB_SELW-1:0] sel,
			input logic we, input logic on);
		if (m == M_DATA) begin
			d_adr   <= adr;
			d_dat_w <= wdat;
			d_sel   <= sel;
			d_we    <= we;
			d_cyc   <= on;
			d_stb   <= on;
		end else begin
			i_adr   <= adr;
			i_dat_w <= wdat;
			i_sel   <= sel;
			i_we    <= we;
			i_cyc   <= on;
			i_stb   <= on;
		end
	endtask

	// One transfer, held until ack or err, then dropped
	task automatic xfer(input int m, input logic [WB_AW-1:0] adr,
			input logic [WB_DW-1:0] wdat, input logic [WB_SELW-1:0] sel, input logic we,
			output logic [WB_DW-1:0] rdat, output logic got_err);
		logic ack;
		logic err;
		logic done;
		@(posedge clk);
		drive_req(m, adr, wdat, sel, we, 1'b1);
		active[m] = 1'b1;
		done = 1'b0;
		rdat = '0;
		got_err = 1'b0;
		while (!done) begin
			@(negedge clk);
			ack = (m == M_DATA) ? d_ack : i_ack;
			err = (m == M_DATA) ? d_err : i_err;
			if (ack && err)
				report_failure("ack and err raised together");
			if (ack || err) begin
				done = 1'b1;
				got_err = err;
				rdat = (m == M_DATA) ? d_dat_r : i_dat_r;
				ack_time[m] = $time;
			end
		end
		@(posedge clk);
		drive_req(m, adr, wdat, sel, we, 1'b0);
		active[m] = 1'b0;
	endtask

	//--------------------------------------------------------------------------
	// Tests
	//--------------------------------------------------------------------------
	// Full words first so every byte is known, then random lanes, then reads
	task automatic mem_test(input int t);
		logic [WB_DW-1:0]   wd;
		logic [WB_DW-1:0]   rd;
		logic [WB_SELW-1:0] sel;
		logic               er;
		int                 w;
		for (int n = 0; n < N_WORDS + N_MIX; n++) begin
			w = (n < N_WORDS) ? n : ($random(seed) & (N_WORDS - 1));
			wd = $random(seed);
			sel = (n < N_WORDS) ? 4'hf : WB_SELW'($random(seed));
			xfer(M_DATA, addr_of(t, w), wd, sel, 1'b1, rd, er);
			if (er)
				report_failure("memory write answered with err");
			ref_set(t, w, merge(ref_get(t, w), wd, sel));
			// A half-word without lanes must keep its old pin value
			if (t == T_SRAM) begin
				check_half("psram low half-word", psram_pins[2 * w], sram_ref[w][15:0]);
				check_half("psram high half-word", psram_pins[2 * w + 1], sram_ref[w][31:16]);
			end
		end
		for (int n = 0; n < N_WORDS; n++) begin
			xfer(n % 2, addr_of(t, n), '0, 4'hf, 1'b0, rd, er);
			check_data(rdata_name(n % 2), rd, ref_get(t, n));
		end
	endtask

	task automatic flash_test();
		logic [WB_DW-1:0] rd;
		logic             er;
		int               w;
		for (int n = 0; n < N_FLASH; n++) begin
			xfer(n % 2, addr_of(T_FLASH, n), '0, 4'hf, 1'b0, rd, er);
			check_data(rdata_name(n % 2), rd, flash_word(n));
		end
		// Writes are ignored
		for (int n = 0; n < N_FWR; n++) begin
			w = $random(seed) & (N_FLASH - 1);
			xfer(M_DATA, addr_of(T_FLASH, w), $random(seed), 4'hf, 1'b1, rd, er);
			if (er)
				report_failure("flash write answered with err");
			xfer(M_INSTR, addr_of(T_FLASH, w), '0, 4'hf, 1'b0, rd, er);
			check_data("i_dat_r_o", rd, flash_word(w));
		end
	endtask

	// Both masters start on the same edge
	task automatic pair_test();
		logic [WB_DW-1:0] rd_d, rd_i;
		logic             er_d, er_i;
		int               td, ti, wd, wi;
		for (int n = 0; n < N_PAIR; n++) begin
			td = ($random(seed) & 1) ? T_SRAM : T_BRAM;
			ti = ($random(seed) & 1) ? T_FLASH : T_BRAM;
			wd = $random(seed) & (N_WORDS - 1);
			wi = $random(seed) & (N_WORDS - 1);
			fork
				xfer(M_DATA, addr_of(td, wd), '0, 4'hf, 1'b0, rd_d, er_d);
				xfer(M_INSTR, addr_of(ti, wi), '0, 4'hf, 1'b0, rd_i, er_i);
			join
			if (er_d || er_i)
				report_failure("mapped read answered with err");
			if (ack_time[M_INSTR] <= ack_time[M_DATA])
				report_failure("instruction master served before data master");
			check_data("d_dat_r_o", rd_d, ref_get(td, wd));
			check_data("i_dat_r_o", rd_i, ref_get(ti, wi));
		end
	endtask

	task automatic gpio_test();
		logic [WB_DW-1:0] wd;
		logic [WB_DW-1:0] rd;
		logic [7:0]       led_ref;
		logic [3:0]       b;
		logic             er;
		led_ref = 8'h00;
		for (int n = 0; n < N_LED; n++) begin
			wd = $random(seed);
			xfer(M_DATA, GPIO_BASE, wd, WB_SELW'($random(seed)) | 4'b0001, 1'b1, rd, er);
			led_ref = wd[7:0];
			check_led(led, led_ref);
		end
		// Lane 0 off, LEDs hold
		xfer(M_DATA, GPIO_BASE, ~wd, 4'b1110, 1'b1, rd, er);
		check_led(led, led_ref);
		for (int n = 0; n < N_BTN; n++) begin
			@(posedge clk);
			b = 4'($random(seed));
			btn <= b;
			repeat (2) @(posedge clk);
			xfer(M_INSTR, GPIO_BASE + 4, '0, 4'hf, 1'b0, rd, er);
			check_data("i_dat_r_o", rd, WB_DW'({b, 8'h00}));
		end
	endtask

	task automatic unmapped_test();
		logic [WB_DW-1:0] rd;
		logic             er;
		for (int m = 0; m < 2; m++) begin
			ce_low_seen = 1'b0;
			xfer(m, BAD_BASE, '0, 4'hf, 1'b0, rd, er);
			if (!er)
				report_failure("unmapped address acknowledged instead of err");
			if (ce_low_seen)
				report_failure("chip enable went low on an unmapped access");
		end
	endtask

	//--------------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------------
	initial begin
		rst = 1'b1;
		i_adr = '0;
		i_dat_w = '0;
		i_sel = '0;
		i_we = 1'b0;
		i_cyc = 1'b0;
		i_stb = 1'b0;
		d_adr = '0;
		d_dat_w = '0;
		d_sel = '0;
		d_we = 1'b0;
		d_cyc = 1'b0;
		d_stb = 1'b0;
		btn = '0;
		active[0] = 1'b0;
		active[1] = 1'b0;
		ce_low_seen = 1'b0;
		checks = 0;
		errors = 0;
		for (int a = 0; a < 256; a++) begin
			psram_pins[a] = {~a[7:0], a[7:0]};
			flash_pins[a] = MEM_DW'($random(seed));
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		// Quiet pins after reset
		@(negedge clk);
		if (i_ack || i_err || d_ack || d_err)
			report_failure("ack or err high after reset");
		if (!sram_ce_n || !flash_ce_n || !mem_oe_n || !mem_we_n)
			report_failure("memory strobe active after reset");
		if (mem_d !== {MEM_DW{1'bz}})
			report_failure("data pins driven after reset");
		check_led(led, 8'h00);
		mem_test(T_BRAM);
		mem_test(T_SRAM);
		flash_test();
		pair_test();
		gpio_test();
		unmapped_test();
		@(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* wb_bram.sv */
// On-chip word RAM, one-cycle ack
// Contents survive reset and start undefined
module wb_bram import soc_pkg::*; (
	input  logic                clk,
	input  logic                rst_i,
	input  wb_addr_t            adr_i,
	input  logic [WB_DW-1:0]    dat_i,
	input  logic [WB_SELW-1:0]  sel_i,
	input  logic                we_i,
	input  logic                stb_i,
	output logic [WB_DW-1:0]    dat_o,
	output logic                ack_o
);

	logic [WB_DW-1:0]    mem [0:(1 << BRAM_AW)-1];
	logic [BRAM_AW-1:0]  word_adr;

	// Word index inside the page
	assign word_adr = adr_i.pg.offset[BRAM_AW+1:2];

	// Single ack pulse per strobe
	always_ff @(posedge clk) begin
		if (rst_i)
			ack_o <= 1'b0;
		else
			ack_o <= stb_i & ~ack_o;
	end

	// Registered read, byte-lane write
	always_ff @(posedge clk) begin
		dat_o <= mem[word_adr];
		if (stb_i && we_i && !ack_o) begin
			for (int b = 0; b < WB_SELW; b++) begin
				if (sel_i[b])
					mem[word_adr][8*b +: 8] <= dat_i[8*b +: 8];
			end
		end
	end

endmodule

/* wb_conbus.sv */
// Two-master Wishbone fabric for four slaves
// Data master wins a tie; the grant stays until the owner drops cyc
// The losing master gets no response at all while it waits
// Unmapped addresses get a registered err and strobe no slave
module wb_conbus import soc_pkg::*; (
	input  logic                clk,
	input  logic                rst_i,
	// Instruction master
	input  logic [WB_AW-1:0]    i_adr_i,
	input  logic [WB_DW-1:0]    i_dat_w_i,
	input  logic [WB_SELW-1:0]  i_sel_i,
	input  logic                i_we_i, i_cyc_i, i_stb_i,
	output logic [WB_DW-1:0]    i_dat_r_o,
	output logic                i_ack_o, i_err_o,
	// Data master
	input  logic [WB_AW-1:0]    d_adr_i,
	input  logic [WB_DW-1:0]    d_dat_w_i,
	input  logic [WB_SELW-1:0]  d_sel_i,
	input  logic                d_we_i, d_cyc_i, d_stb_i,
	output logic [WB_DW-1:0]    d_dat_r_o,
	output logic                d_ack_o, d_err_o,
	// Shared slave request
	output wb_addr_t            adr_o,
	output logic [WB_DW-1:0]    dat_o,
	output logic [WB_SELW-1:0]  sel_o,
	output logic                we_o, cyc_o,
	output logic                sram_stb_o, flash_stb_o, bram_stb_o, gpio_stb_o,
	// Slave responses
	input  logic [WB_DW-1:0]    sram_dat_i, flash_dat_i, bram_dat_i, gpio_dat_i,
	input  logic                sram_ack_i, flash_ack_i, bram_ack_i, gpio_ack_i
);

	logic                busy;
	logic                gnt_d;
	logic                err_q;
	wb_addr_t            m_adr;
	logic [WB_DW-1:0]    m_dat;
	logic [WB_SELW-1:0]  m_sel;
	logic                m_we, m_cyc, m_stb;
	logic                req;
	slave_e              slv;
	logic [WB_DW-1:0]    s_dat;
	logic                s_ack;

	//--------------------------------------------------------------------------
	// Arbiter
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy  <= 1'b0;
			gnt_d <= 1'b0;
		end else if (!busy) begin
			// Free bus, data master has priority
			if (d_cyc_i || i_cyc_i) begin
				busy  <= 1'b1;
				gnt_d <= d_cyc_i;
			end
		end else if (!m_cyc) begin
			busy <= 1'b0;
		end
	end

	// Granted master onto the shared request
	always_comb begin
		if (gnt_d) begin
			m_adr = d_adr_i;
			m_dat = d_dat_w_i;
			m_sel = d_sel_i;
			m_we  = d_we_i;
			m_cyc = d_cyc_i;
			m_stb = d_stb_i;
		end else begin
			m_adr = i_adr_i;
			m_dat = i_dat_w_i;
			m_sel = i_sel_i;
			m_we  = i_we_i;
			m_cyc = i_cyc_i;
			m_stb = i_stb_i;
		end
	end

	assign req   = busy & m_cyc & m_stb;
	assign adr_o = m_adr;
	assign dat_o = m_dat;
	assign sel_o = m_sel;
	assign we_o  = m_we;
	assign cyc_o = busy & m_cyc;

	//--------------------------------------------------------------------------
	// Address decoder
	//--------------------------------------------------------------------------
	// Large regions first, then the small pages
	always_comb begin
		slv = SLV_NONE;
		if (m_adr.rgn.region == REGION_SRAM)
			slv = SLV_SRAM;
		else if (m_adr.rgn.region == REGION_FLASH)
			slv = SLV_FLASH;
		else if (m_adr.pg.page == PAGE_BRAM)
			slv = SLV_BRAM;
		else if (m_adr.pg.page == PAGE_GPIO)
			slv = SLV_GPIO;
	end

	assign sram_stb_o  = req & (slv == SLV_SRAM);
	assign flash_stb_o = req & (slv == SLV_FLASH);
	assign bram_stb_o  = req & (slv == SLV_BRAM);
	assign gpio_stb_o  = req & (slv == SLV_GPIO);

	// Unmapped, one err pulse per request
	always_ff @(posedge clk) begin
		if (rst_i)
			err_q <= 1'b0;
		else
			err_q <= req && (slv == SLV_NONE) && !err_q;
	end

	//--------------------------------------------------------------------------
	// Return path
	//--------------------------------------------------------------------------
	always_comb begin
		case (slv)
			SLV_SRAM: begin
				s_dat = sram_dat_i;
				s_ack = sram_ack_i;
			end
			SLV_FLASH: begin
				s_dat = flash_dat_i;
				s_ack = flash_ack_i;
			end
			SLV_BRAM: begin
				s_dat = bram_dat_i;
				s_ack = bram_ack_i;
			end
			SLV_GPIO: begin
				s_dat = gpio_dat_i;
				s_ack = gpio_ack_i;
			end
			default: begin
				s_dat = '0;
				s_ack = 1'b0;
			end
		endcase
	end

	// Only the owner of the grant sees a response
	assign d_ack_o   = busy & gnt_d & s_ack;
	assign i_ack_o   = busy & ~gnt_d & s_ack;
	assign d_err_o   = busy & gnt_d & err_q;
	assign i_err_o   = busy & ~gnt_d & err_q;
	assign d_dat_r_o = gnt_d ? s_dat : '0;
	assign i_dat_r_o = gnt_d ? '0 : s_dat;

endmodule

/* wb_gpio.sv */
// LED and button port, one-cycle ack
// Offset 0: LEDs, written through byte lane 0
// Offset 4: buttons in bits 11..8, read only; other offsets read zero
module wb_gpio import soc_pkg::*; (
	input  logic                clk,
	input  logic                rst_i,
	input  wb_addr_t            adr_i,
	input  logic [WB_DW-1:0]    dat_i,
	input  logic [WB_SELW-1:0]  sel_i,
	input  logic                we_i,
	input  logic                stb_i,
	output logic [WB_DW-1:0]    dat_o,
	output logic                ack_o,
	input  logic [3:0]          btn_i,
	output logic [7:0]          led_o
);

	logic [WB_AW-PAGE_W-3:0] reg_idx;
	logic [3:0]              btn_q;

	// Word index inside the page
	assign reg_idx = adr_i.pg.offset[WB_AW-PAGE_W-1:2];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			led_o <= '0;
		end else begin
			ack_o <= stb_i & ~ack_o;
			if (stb_i && we_i && !ack_o && sel_i[0] && reg_idx == '0)
				led_o <= dat_i[7:0];
		end
	end

	// Button sampling and read mux
	always_ff @(posedge clk) begin
		btn_q <= btn_i;
		if (reg_idx == '0)
			dat_o <= WB_DW'(led_o);
		else if (reg_idx == 1)
			dat_o <= WB_DW'({btn_q, 8'h00});
		else
			dat_o <= '0;
	end

endmodule

/* wb_sram16.sv */
// Wishbone word access on a 16-bit asynchronous PSRAM
// Lower half-word first; a write half with no byte select is skipped
// Each half gets one setup cycle before SRAM_LATENCY cycles of strobes
// Reads fetch both halves with both byte lanes enabled
module wb_sram16 import soc_pkg::*; (
	input  logic                clk,
	input  logic                rst_i,
	input  wb_addr_t            adr_i,
	input  logic [WB_DW-1:0]    dat_i,
	input  logic [WB_SELW-1:0]  sel_i,
	input  logic                we_i,
	input  logic                stb_i,
	output logic [WB_DW-1:0]    dat_o,
	output logic                ack_o,
	// PSRAM side
	output logic [SRAM_AW-1:0]  sram_adr_o,
	output logic [MEM_DW-1:0]   sram_dat_o,
	input  logic [MEM_DW-1:0]   sram_dat_i,
	output logic [MEM_DW/8-1:0] sram_be_n_o,
	output logic                sram_ce_n_o,
	output logic                sram_oe_n_o,
	output logic                sram_we_n_o
);

	logic                busy;
	logic                gap;
	logic                upper;
	logic [LAT_W-1:0]    cnt;
	logic                lo_en, hi_en;
	logic                load_hi;
	logic [MEM_DW/8-1:0] half_sel;

	// Halves taking part in this access
	assign lo_en = ~we_i | (|sel_i[1:0]);
	assign hi_en = ~we_i | (|sel_i[3:2]);

	// Upper half loaded at start if the lower is skipped, else after the lower window
	assign load_hi  = busy | ~lo_en;
	assign half_sel = load_hi ? sel_i[3:2] : sel_i[1:0];

	//--------------------------------------------------------------------------
	// Sequencer
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy        <= 1'b0;
			gap         <= 1'b0;
			upper       <= 1'b0;
			cnt         <= '0;
			ack_o       <= 1'b0;
			sram_ce_n_o <= 1'b1;
			sram_oe_n_o <= 1'b1;
			sram_we_n_o <= 1'b1;
		end else begin
			ack_o <= 1'b0;
			if (!busy) begin
				if (stb_i && !ack_o) begin
					if (!lo_en && !hi_en) begin
						// Write with no lanes needs no access
						ack_o <= 1'b1;
					end else begin
						busy        <= 1'b1;
						gap         <= 1'b1;
						upper       <= ~lo_en;
						sram_ce_n_o <= 1'b0;
						sram_oe_n_o <= we_i;
					end
				end
			end else if (gap) begin
				// Strobe window opens after the setup cycle
				gap         <= 1'b0;
				cnt         <= LAT_W'(SRAM_LATENCY - 1);
				sram_we_n_o <= ~we_i;
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				sram_we_n_o <= 1'b1;
				if (!upper && hi_en) begin
					upper <= 1'b1;
					gap   <= 1'b1;
				end else begin
					// Last half done
					busy        <= 1'b0;
					ack_o       <= 1'b1;
					sram_ce_n_o <= 1'b1;
					sram_oe_n_o <= 1'b1;
				end
			end
		end
	end

	//--------------------------------------------------------------------------
	// Address, write data and read assembly
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		// Upper half set up as soon as the lower window closes
		if (!busy || (!gap && cnt == '0 && !upper)) begin
			// Half-word address is word offset times two plus half
			sram_adr_o  <= {adr_i.rgn.offset[SRAM_AW:2], load_hi};
			sram_dat_o  <= load_hi ? dat_i[WB_DW-1:MEM_DW] : dat_i[MEM_DW-1:0];
			sram_be_n_o <= we_i ? ~half_sel : '0;
		end
		if (busy && !gap && cnt == '0) begin
			// End of a strobe window
			if (upper)
				dat_o[WB_DW-1:MEM_DW] <= sram_dat_i;
			else
				dat_o[MEM_DW-1:0] <= sram_dat_i;
		end
	end

endmodule
